//--- logic/rx_bus_pkg.sv
package rx_bus_pkg;

	// Stream, packet buffer and host port share one word size
	localparam int BUS_DATA_W = 32;
	localparam int BUS_STRB_W = BUS_DATA_W / 8;
	localparam int HOST_ADDR_W = 64; // Host byte address

	typedef logic [BUS_DATA_W-1:0] word_t;
	typedef logic [BUS_STRB_W-1:0] strb_t;
	typedef logic [HOST_ADDR_W-1:0] host_addr_t;

endpackage

//--- logic/rx_ring_pkg.sv
package rx_ring_pkg;

	localparam int RING_IDX_W = 16;

	typedef logic [RING_IDX_W-1:0] ring_idx_t;
	typedef logic [15:0] frame_len_t; // Bytes
	typedef logic [1:0] bsize_t;

	// One received frame as stored in the packet buffer
	typedef struct packed {
		logic [15:0] start; // Buffer word index
		frame_len_t len;
	} frame_rec_t;

	// Host buffer size in bytes per size code
	function automatic frame_len_t buf_bytes(input bsize_t code);
		case (code)
			2'd0: return 16'd2048;
			2'd1: return 16'd1024;
			2'd2: return 16'd512;
			default: return 16'd256;
		endcase
	endfunction

endpackage

//--- logic/rx_frame_writer.sv
`timescale 1ns/100ps

module rx_frame_writer import rx_bus_pkg::*, rx_ring_pkg::*; #(
	parameter int BUF_WORDS = 512,
	localparam int AW = $clog2(BUF_WORDS)
) (
	input  logic          aclk,
	input  logic          rst_i,
	input  logic          en_i,
	input  word_t         mac_s_tdata_i,
	input  strb_t         mac_s_tkeep_i,
	input  logic          mac_s_tlast_i,
	input  logic          mac_s_tvalid_i,
	output logic          mac_s_tready_o,
	input  logic          buf_gnt_i,
	input  logic          q_full_i,
	input  logic          free_stb_i,
	input  logic [AW:0]   free_words_i,
	output logic          buf_req_o,
	output logic [AW-1:0] buf_addr_o,
	output word_t         buf_data_o,
	output logic          q_push_o,
	output frame_rec_t    q_rec_o
);
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] next_ptr;
	logic [AW-1:0] start_ptr;
	logic [AW-1:0] cur_start;
	logic [AW:0] free_cnt;
	logic [AW:0] frm_words;
	logic [AW:0] restore;
	frame_len_t len_cnt;
	logic [2:0] nbytes;
	logic in_frame;
	logic discard;
	logic cur_discard;
	logic acc;

	// tkeep is contiguous from byte 0
	always_comb
	begin
		nbytes = '0;
		for (int i = 0; i < BUS_STRB_W; i++)
			nbytes = nbytes + 3'(mac_s_tkeep_i[i]);
	end

	assign acc = mac_s_tvalid_i && buf_gnt_i;
	assign next_ptr = (wr_ptr == AW'(BUF_WORDS - 1)) ? '0 : wr_ptr + 1'b1;
	assign cur_start = in_frame ? start_ptr : wr_ptr;
	assign cur_discard = in_frame ? discard : !en_i; // Decided on the first word
	assign restore = (acc && mac_s_tlast_i && cur_discard) ? frm_words + 1'b1 : '0;

	// A last word also waits out a record push still in flight
	assign buf_req_o = mac_s_tvalid_i && (free_cnt != '0)
		&& !(mac_s_tlast_i && (q_full_i || q_push_o));
	assign mac_s_tready_o = buf_gnt_i;
	assign buf_addr_o = wr_ptr;
	assign buf_data_o = mac_s_tdata_i;

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			free_cnt <= (AW+1)'(BUF_WORDS);
			in_frame <= 1'b0;
			discard <= 1'b0;
			len_cnt <= '0;
			frm_words <= '0;
			q_push_o <= 1'b0;
		end
		else
		begin
			q_push_o <= acc && mac_s_tlast_i && !cur_discard;
			free_cnt <= free_cnt - (AW+1)'(acc) + restore
				+ (free_stb_i ? free_words_i : '0);
			if (acc)
			begin
				if (mac_s_tlast_i)
				begin
					in_frame <= 1'b0;
					len_cnt <= '0;
					frm_words <= '0;
					wr_ptr <= cur_discard ? cur_start : next_ptr; // Rewind a dropped frame
				end
				else
				begin
					in_frame <= 1'b1;
					discard <= cur_discard;
					len_cnt <= len_cnt + 16'(nbytes);
					frm_words <= frm_words + 1'b1;
					wr_ptr <= next_ptr;
				end
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (acc && !mac_s_tlast_i)
			start_ptr <= cur_start;
		if (acc && mac_s_tlast_i)
			q_rec_o <= '{start: 16'(cur_start), len: len_cnt + 16'(nbytes)};
	end

	a_no_push_full: assert property (@(posedge aclk) disable iff (rst_i)
		q_push_o |-> !q_full_i)
		else $error("frame record pushed while the queue is full");

endmodule

//--- logic/rx_frame_queue.sv
`timescale 1ns/100ps

module rx_frame_queue import rx_ring_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1
) (
	input  logic       aclk,
	input  logic       rst_i,
	input  logic       push_i,
	input  frame_rec_t rec_i,
	input  logic       pop_i,
	output logic       full_o,
	output logic       valid_o,
	output frame_rec_t rec_o
);
	frame_rec_t mem [QUEUE_DEPTH];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [PW:0] count;

	function automatic logic [PW-1:0] bump(input logic [PW-1:0] ptr);
		return (ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign full_o = (count == (PW+1)'(QUEUE_DEPTH));
	assign valid_o = (count != '0);
	assign rec_o = mem[rd_ptr];

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push_i)
				wr_ptr <= bump(wr_ptr);
			if (pop_i)
				rd_ptr <= bump(rd_ptr);
			count <= count + (PW+1)'(push_i) - (PW+1)'(pop_i);
		end
	end

	always_ff @(posedge aclk)
	begin
		if (push_i)
			mem[wr_ptr] <= rec_i;
	end

	a_push_full: assert property (@(posedge aclk) disable iff (rst_i) push_i |-> !full_o)
		else $error("push into a full frame queue");
	a_pop_empty: assert property (@(posedge aclk) disable iff (rst_i) pop_i |-> valid_o)
		else $error("pop from an empty frame queue");

endmodule

//--- logic/rx_packet_buffer.sv
`timescale 1ns/100ps

module rx_packet_buffer import rx_bus_pkg::*; #(
	parameter int BUF_WORDS = 512,
	localparam int AW = $clog2(BUF_WORDS)
) (
	input  logic          aclk,
	input  logic          rst_i,
	input  logic          wr_req_i,
	input  logic [AW-1:0] wr_addr_i,
	input  word_t         wr_data_i,
	output logic          wr_gnt_o,
	input  logic          rd_req_i,
	input  logic [AW-1:0] rd_addr_i,
	output logic          rd_gnt_o,
	output word_t         rd_data_o
);
	word_t mem [BUF_WORDS];
	logic last_wr; // Writer had the last grant

	// On a tie the requester without the last grant wins
	always_comb
	begin
		wr_gnt_o = wr_req_i && (!rd_req_i || !last_wr);
		rd_gnt_o = rd_req_i && (!wr_req_i || last_wr);
	end

	always_ff @(posedge aclk)
	begin
		if (rst_i)
			last_wr <= 1'b0;
		else if (wr_gnt_o)
			last_wr <= 1'b1;
		else if (rd_gnt_o)
			last_wr <= 1'b0;
	end

	always_ff @(posedge aclk)
	begin
		if (wr_gnt_o)
			mem[wr_addr_i] <= wr_data_i;
		if (rd_gnt_o)
			rd_data_o <= mem[rd_addr_i]; // Valid the cycle after the grant
	end

	// A refused read stays up at the same address until granted
	a_rd_held: assert property (@(posedge aclk) disable iff (rst_i)
		rd_req_i && !rd_gnt_o |=> rd_req_i && $stable(rd_addr_i))
		else $error("refused buffer read was withdrawn or moved");

endmodule

//--- logic/rx_ring_ctrl.sv
`timescale 1ns/100ps

module rx_ring_ctrl import rx_bus_pkg::*, rx_ring_pkg::*; (
	input  logic       aclk,
	input  logic       rst_i,
	input  host_addr_t rdba_i,
	input  bsize_t     bsize_i,
	input  ring_idx_t  rdlen_i,
	input  ring_idx_t  rdh_i,
	input  logic       rdh_set_i,
	input  ring_idx_t  rdt_i,
	input  logic       rdt_set_i,
	input  logic [1:0] rdmts_i,
	input  logic       desc_done_i,
	output logic       desc_avail_o,
	output host_addr_t buf_addr_o,
	output ring_idx_t  rdh_fb_o,
	output logic       rxt0_req_o,
	output logic       rxdmt0_req_o
);
	ring_idx_t head;
	ring_idx_t tail;
	ring_idx_t free_cnt;
	ring_idx_t free_next;
	ring_idx_t thresh;

	// Free descriptors between head and tail, modulo ring length
	assign free_cnt = (tail >= head) ? tail - head : rdlen_i - head + tail;
	assign free_next = free_cnt - 1'b1; // After the head moves on
	assign thresh = rdlen_i >> ({1'b0, rdmts_i} + 3'd1);

	assign desc_avail_o = (free_cnt != '0);
	assign buf_addr_o = rdba_i + host_addr_t'(head) * host_addr_t'(buf_bytes(bsize_i));
	assign rdh_fb_o = head;

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			head <= '0;
			tail <= '0;
			rxt0_req_o <= 1'b0;
			rxdmt0_req_o <= 1'b0;
		end
		else
		begin
			rxt0_req_o <= desc_done_i;
			rxdmt0_req_o <= desc_done_i && (free_next == thresh);
			if (rdh_set_i)
				head <= rdh_i;
			else if (desc_done_i)
				head <= (head == rdlen_i - 1'b1) ? '0 : head + 1'b1;
			if (rdt_set_i)
				tail <= rdt_i;
		end
	end

endmodule

//--- logic/rx_dma.sv
`timescale 1ns/100ps

module rx_dma import rx_bus_pkg::*, rx_ring_pkg::*; #(
	parameter int BUF_WORDS = 512,
	localparam int AW = $clog2(BUF_WORDS)
) (
	input  logic          aclk,
	input  logic          rst_i,
	input  logic          q_valid_i,
	input  frame_rec_t    q_rec_i,
	output logic          q_pop_o,
	input  logic          desc_avail_i,
	input  host_addr_t    buf_addr_i,
	input  bsize_t        bsize_i,
	output logic          rd_req_o,
	output logic [AW-1:0] rd_addr_o,
	input  logic          rd_gnt_i,
	input  word_t         rd_data_i,
	output host_addr_t    host_awaddr_o,
	output word_t         host_wdata_o,
	output strb_t         host_wstrb_o,
	output logic          host_wvalid_o,
	input  logic          host_wready_i,
	output logic          desc_done_o,
	output logic          free_stb_o,
	output logic [AW:0]   free_words_o,
	output logic          rxo_req_o
);
	typedef enum logic [1:0] {S_IDLE, S_COPY, S_FINISH} state_t;

	localparam logic [AW:0] ONE_WORD = 1;

	state_t state;
	frame_len_t cp_len;
	strb_t tail_strb;
	strb_t last_strb;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] rd_left;
	logic [AW:0] wr_left;
	logic [AW:0] tot_words;
	logic pend; // Buffer read in flight
	logic start;
	logic drop;
	logic wr_xfer;

	function automatic logic [AW:0] word_cnt(input frame_len_t len);
		logic [16:0] w;
		w = ({1'b0, len} + 17'd3) >> 2;
		return w[AW:0];
	endfunction

	// Truncate to the host buffer
	assign cp_len = (q_rec_i.len > buf_bytes(bsize_i)) ? buf_bytes(bsize_i) : q_rec_i.len;
	assign tail_strb = (cp_len[1:0] == 2'd0) ? '1 : strb_t'((5'd1 << cp_len[1:0]) - 5'd1);

	assign q_pop_o = (state == S_IDLE) && q_valid_i;
	assign start = q_pop_o && desc_avail_i;
	assign drop = q_pop_o && !desc_avail_i; // No descriptor, overrun
	assign wr_xfer = host_wvalid_o && host_wready_i;

	assign rd_req_o = (state == S_COPY) && (rd_left != '0) && !pend && !host_wvalid_o;
	assign rd_addr_o = rd_ptr;
	assign desc_done_o = (state == S_COPY) && wr_xfer && (wr_left == ONE_WORD);
	assign free_stb_o = drop || (state == S_FINISH);
	assign free_words_o = (state == S_FINISH) ? tot_words : word_cnt(q_rec_i.len);

	always_ff @(posedge aclk)
	begin
		if (rst_i)
		begin
			state <= S_IDLE;
			pend <= 1'b0;
			host_wvalid_o <= 1'b0;
			rxo_req_o <= 1'b0;
			rd_left <= '0;
			wr_left <= '0;
		end
		else
		begin
			rxo_req_o <= drop;
			pend <= rd_req_o && rd_gnt_i;
			case (state)
				S_IDLE:
				begin
					if (start)
					begin
						rd_left <= word_cnt(cp_len);
						wr_left <= word_cnt(cp_len);
						state <= S_COPY;
					end
				end
				S_COPY:
				begin
					if (rd_req_o && rd_gnt_i)
						rd_left <= rd_left - 1'b1;
					if (pend)
						host_wvalid_o <= 1'b1;
					else if (wr_xfer)
					begin
						host_wvalid_o <= 1'b0;
						wr_left <= wr_left - 1'b1;
						if (wr_left == ONE_WORD)
							state <= S_FINISH;
					end
				end
				default: state <= S_IDLE; // Buffer space returned
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (start)
		begin
			rd_ptr <= q_rec_i.start[AW-1:0];
			host_awaddr_o <= buf_addr_i;
			tot_words <= word_cnt(q_rec_i.len);
			last_strb <= tail_strb;
		end
		if (rd_req_o && rd_gnt_i)
			rd_ptr <= (rd_ptr == AW'(BUF_WORDS - 1)) ? '0 : rd_ptr + 1'b1;
		if (pend)
		begin
			host_wdata_o <= rd_data_i;
			host_wstrb_o <= (wr_left == ONE_WORD) ? last_strb : '1;
		end
		if (wr_xfer)
			host_awaddr_o <= host_awaddr_o + HOST_ADDR_W'(4);
	end

	a_host_hold: assert property (@(posedge aclk) disable iff (rst_i)
		host_wvalid_o && !host_wready_i |=> host_wvalid_o && $stable(host_awaddr_o)
			&& $stable(host_wdata_o) && $stable(host_wstrb_o))
		else $error("host write changed before it was accepted");

endmodule

//--- logic/rx_path.sv
`timescale 1ns/100ps

module rx_path import rx_bus_pkg::*, rx_ring_pkg::*; #(
	parameter int BUF_WORDS = 512,
	parameter int QUEUE_DEPTH = 4,
	localparam int AW = $clog2(BUF_WORDS)
) (
	input  logic       aclk,
	input  logic       rst_i,
	input  word_t      mac_s_tdata_i,
	input  strb_t      mac_s_tkeep_i,
	input  logic       mac_s_tlast_i,
	input  logic       mac_s_tvalid_i,
	output logic       mac_s_tready_o,
	output host_addr_t host_awaddr_o,
	output word_t      host_wdata_o,
	output strb_t      host_wstrb_o,
	output logic       host_wvalid_o,
	input  logic       host_wready_i,
	input  logic       en_i,
	input  bsize_t     bsize_i,
	input  host_addr_t rdba_i,
	input  ring_idx_t  rdlen_i,
	input  ring_idx_t  rdh_i,
	input  logic       rdh_set_i,
	input  ring_idx_t  rdt_i,
	input  logic       rdt_set_i,
	input  logic [1:0] rdmts_i,
	output ring_idx_t  rdh_fb_o,
	output logic       rxt0_req_o,
	output logic       rxo_req_o,
	output logic       rxdmt0_req_o
);
	logic wr_req, wr_gnt, rd_req, rd_gnt;
	logic [AW-1:0] wr_addr, rd_addr;
	word_t wr_data, rd_data;
	logic q_push, q_full, q_valid, q_pop;
	frame_rec_t q_rec_in, q_rec_out;
	logic free_stb;
	logic [AW:0] free_words;
	logic desc_avail, desc_done;
	host_addr_t buf_addr;

	rx_frame_writer #(.BUF_WORDS(BUF_WORDS)) u_writer (
		.aclk(aclk), .rst_i(rst_i), .en_i(en_i),
		.mac_s_tdata_i(mac_s_tdata_i), .mac_s_tkeep_i(mac_s_tkeep_i),
		.mac_s_tlast_i(mac_s_tlast_i), .mac_s_tvalid_i(mac_s_tvalid_i),
		.mac_s_tready_o(mac_s_tready_o),
		.buf_gnt_i(wr_gnt), .q_full_i(q_full),
		.free_stb_i(free_stb), .free_words_i(free_words),
		.buf_req_o(wr_req), .buf_addr_o(wr_addr), .buf_data_o(wr_data),
		.q_push_o(q_push), .q_rec_o(q_rec_in)
	);

	rx_frame_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_queue (
		.aclk(aclk), .rst_i(rst_i),
		.push_i(q_push), .rec_i(q_rec_in), .pop_i(q_pop),
		.full_o(q_full), .valid_o(q_valid), .rec_o(q_rec_out)
	);

	// Writer and DMA share the single port
	rx_packet_buffer #(.BUF_WORDS(BUF_WORDS)) u_buffer (
		.aclk(aclk), .rst_i(rst_i),
		.wr_req_i(wr_req), .wr_addr_i(wr_addr), .wr_data_i(wr_data), .wr_gnt_o(wr_gnt),
		.rd_req_i(rd_req), .rd_addr_i(rd_addr), .rd_gnt_o(rd_gnt), .rd_data_o(rd_data)
	);

	rx_ring_ctrl u_ring (
		.aclk(aclk), .rst_i(rst_i),
		.rdba_i(rdba_i), .bsize_i(bsize_i), .rdlen_i(rdlen_i),
		.rdh_i(rdh_i), .rdh_set_i(rdh_set_i), .rdt_i(rdt_i), .rdt_set_i(rdt_set_i),
		.rdmts_i(rdmts_i), .desc_done_i(desc_done),
		.desc_avail_o(desc_avail), .buf_addr_o(buf_addr), .rdh_fb_o(rdh_fb_o),
		.rxt0_req_o(rxt0_req_o), .rxdmt0_req_o(rxdmt0_req_o)
	);

	rx_dma #(.BUF_WORDS(BUF_WORDS)) u_dma (
		.aclk(aclk), .rst_i(rst_i),
		.q_valid_i(q_valid), .q_rec_i(q_rec_out), .q_pop_o(q_pop),
		.desc_avail_i(desc_avail), .buf_addr_i(buf_addr), .bsize_i(bsize_i),
		.rd_req_o(rd_req), .rd_addr_o(rd_addr), .rd_gnt_i(rd_gnt), .rd_data_i(rd_data),
		.host_awaddr_o(host_awaddr_o), .host_wdata_o(host_wdata_o),
		.host_wstrb_o(host_wstrb_o), .host_wvalid_o(host_wvalid_o),
		.host_wready_i(host_wready_i),
		.desc_done_o(desc_done), .free_stb_o(free_stb), .free_words_o(free_words),
		.rxo_req_o(rxo_req_o)
	);

endmodule

//--- verif/tb_rx_path.sv
`timescale 1ns/100ps

module tb_rx_path
	import rx_bus_pkg::*, rx_ring_pkg::*;
();
	localparam int MAC_LIMIT = 4000; // Cycles per stream word
	localparam int IDLE_LIMIT = 20000;

	logic aclk;
	logic rst_i;
	word_t mac_s_tdata_i;
	strb_t mac_s_tkeep_i;
	logic mac_s_tlast_i;
	logic mac_s_tvalid_i;
	logic mac_s_tready_o;
	host_addr_t host_awaddr_o;
	word_t host_wdata_o;
	strb_t host_wstrb_o;
	logic host_wvalid_o;
	logic host_wready_i;
	logic en_i;
	bsize_t bsize_i;
	host_addr_t rdba_i;
	ring_idx_t rdlen_i;
	ring_idx_t rdh_i;
	ring_idx_t rdt_i;
	ring_idx_t rdh_fb_o;
	logic rdh_set_i;
	logic rdt_set_i;
	logic [1:0] rdmts_i;
	logic rxt0_req_o;
	logic rxo_req_o;
	logic rxdmt0_req_o;

	// Expected host writes in arrival order
	host_addr_t exp_addr[$];
	word_t exp_data[$];
	strb_t exp_strb[$];
	// One expected interrupt pulse per frame that reaches the DMA
	int ev_kind[$];
	int ev_rdh[$];
	int ev_thr[$];
	int ev_wend[$];

	int writes_pushed;
	int writes_seen;
	int head; // Model of the ring head
	int mismatches;
	int failures;
	int timeouts;

	rx_path #(.BUF_WORDS(512), .QUEUE_DEPTH(4)) u_dut (.*);

	always #2 aclk = ~aclk;

	// Host back-pressure
	always @(negedge aclk)
		host_wready_i = ($urandom % 4) != 0;

	task automatic report_mismatch(input string msg);
		mismatches++;
		$display("mismatch at %0t ns: %s", $time, msg);
	endtask

	task automatic report_failure(input string msg);
		failures++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// Byte i of a frame is first + i and bytes past the end are zero
	function automatic word_t frame_word(input int first, input int k, input int len);
		word_t w;
		w = '0;
		for (int j = 0; j < BUS_STRB_W; j++)
			if (4 * k + j < len)
				w[8*j +: 8] = 8'((first + 4 * k + j) % 256);
		return w;
	endfunction

	function automatic strb_t keep_for(input int n);
		return strb_t'((1 << n) - 1);
	endfunction

	function automatic word_t strb_mask(input strb_t s);
		word_t m;
		for (int j = 0; j < BUS_STRB_W; j++)
			m[8*j +: 8] = {8{s[j]}};
		return m;
	endfunction

	always @(posedge aclk)
	begin : host_monitor
		word_t m;
		if (!rst_i && host_wvalid_o && host_wready_i)
		begin
			if (exp_addr.size() == 0)
				report_failure("host write with no frame waiting for it");
			else
			begin
				m = strb_mask(exp_strb[0]);
				assert (host_awaddr_o == exp_addr[0])
					else report_mismatch($sformatf("host address %h, expected %h",
						host_awaddr_o, exp_addr[0]));
				assert (host_wstrb_o == exp_strb[0])
					else report_mismatch($sformatf("host strobe %h, expected %h",
						host_wstrb_o, exp_strb[0]));
				assert ((host_wdata_o & m) == (exp_data[0] & m))
					else report_mismatch($sformatf("host data %h, expected %h",
						host_wdata_o & m, exp_data[0] & m));
				void'(exp_addr.pop_front());
				void'(exp_data.pop_front());
				void'(exp_strb.pop_front());
			end
			writes_seen++;
		end
		if (!rst_i && (rxt0_req_o || rxo_req_o))
		begin
			if (ev_kind.size() == 0)
				report_failure("interrupt pulse with no frame waiting for it");
			else
			begin
				assert (rxo_req_o == (ev_kind[0] == 1) && rxt0_req_o == (ev_kind[0] == 0))
					else report_mismatch($sformatf("rxt0 %b rxo %b, expected outcome %0d",
						rxt0_req_o, rxo_req_o, ev_kind[0]));
				assert (int'(rdh_fb_o) == ev_rdh[0])
					else report_mismatch($sformatf("head feedback %0d, expected %0d",
						rdh_fb_o, ev_rdh[0]));
				assert (int'(rxdmt0_req_o) == ev_thr[0])
					else report_mismatch($sformatf("threshold pulse %b, expected %0d",
						rxdmt0_req_o, ev_thr[0]));
				assert (writes_seen == ev_wend[0])
					else report_mismatch($sformatf("%0d host writes at frame end, expected %0d",
						writes_seen, ev_wend[0]));
				void'(ev_kind.pop_front());
				void'(ev_rdh.pop_front());
				void'(ev_thr.pop_front());
				void'(ev_wend.pop_front());
			end
		end
		else if (!rst_i && rxdmt0_req_o)
			report_failure("threshold interrupt without a delivery");
	end

	task automatic expect_frame(input int len, input int first, input int outcome,
		input int rdh_after, input int thr);
		int bytes;
		int cp;
		int nw;
		bytes = 2048 >> bsize_i;
		if (outcome == 0)
		begin
			cp = (len > bytes) ? bytes : len; // Truncated to the host buffer
			nw = (cp + 3) / 4;
			for (int k = 0; k < nw; k++)
			begin
				exp_addr.push_back(rdba_i + host_addr_t'(head * bytes + 4 * k));
				exp_data.push_back(frame_word(first, k, len));
				exp_strb.push_back((k == nw - 1) ? keep_for(cp - 4 * k) : 4'hf);
			end
			writes_pushed += nw;
			head = (head + 1) % int'(rdlen_i);
		end
		if (outcome != 2)
		begin
			ev_kind.push_back(outcome);
			ev_rdh.push_back(rdh_after);
			ev_thr.push_back(thr);
			ev_wend.push_back(writes_pushed);
		end
	endtask

	// Starts and ends on a falling edge
	task automatic send_frame(input int len, input int first, input int gap);
		int nw;
		int cnt;
		logic accepted;
		nw = (len + 3) / 4;
		for (int k = 0; k < nw; k++)
		begin
			if (gap[k % 8])
			begin
				mac_s_tvalid_i = 1'b0;
				@(negedge aclk);
			end
			mac_s_tdata_i = frame_word(first, k, len);
			mac_s_tkeep_i = (k == nw - 1) ? keep_for(len - 4 * k) : 4'hf;
			mac_s_tlast_i = (k == nw - 1);
			mac_s_tvalid_i = 1'b1;
			cnt = 0;
			do
			begin
				@(posedge aclk);
				cnt++;
			end
			while (!mac_s_tready_o && cnt < MAC_LIMIT);
			accepted = mac_s_tready_o;
			@(negedge aclk);
			if (!accepted)
			begin
				report_failure("MAC stream word was never accepted");
				timeouts++;
				break;
			end
		end
		mac_s_tvalid_i = 1'b0;
		mac_s_tlast_i = 1'b0;
	endtask

	task automatic wait_idle();
		int cnt;
		cnt = 0;
		while ((ev_kind.size() != 0 || exp_addr.size() != 0) && cnt < IDLE_LIMIT)
		begin
			@(negedge aclk);
			cnt++;
		end
		if (cnt >= IDLE_LIMIT)
		begin
			report_failure("DUT did not finish the queued frames in time");
			timeouts++;
		end
	endtask

	task automatic load_ring(input host_addr_t base, input int code, input int len,
		input int rdh, input int rdt, input int mts);
		wait_idle();
		rdba_i = base;
		bsize_i = bsize_t'(code);
		rdlen_i = ring_idx_t'(len);
		rdmts_i = 2'(mts);
		rdh_i = ring_idx_t'(rdh);
		rdt_i = ring_idx_t'(rdt);
		rdh_set_i = 1'b1;
		rdt_set_i = 1'b1;
		@(negedge aclk);
		rdh_set_i = 1'b0;
		rdt_set_i = 1'b0;
		head = rdh;
	endtask

	task automatic load_tail(input int rdt);
		wait_idle();
		rdt_i = ring_idx_t'(rdt);
		rdt_set_i = 1'b1;
		@(negedge aclk);
		rdt_set_i = 1'b0;
	endtask

	initial
	begin
		int fd;
		int n;
		int need;
		int v[6];
		host_addr_t a;
		string line;
		byte kind;
		void'($urandom(22));
		aclk = 1'b0;
		rst_i = 1'b1;
		mac_s_tdata_i = '0;
		mac_s_tkeep_i = '0;
		mac_s_tlast_i = 1'b0;
		mac_s_tvalid_i = 1'b0;
		host_wready_i = 1'b0;
		en_i = 1'b1;
		bsize_i = '0;
		rdba_i = '0;
		rdlen_i = 16'd8;
		rdh_i = '0;
		rdt_i = '0;
		rdh_set_i = 1'b0;
		rdt_set_i = 1'b0;
		rdmts_i = '0;
		repeat (8) @(negedge aclk);
		rst_i = 1'b0;
		fd = $fopen("verif/rx_trace.txt", "r");
		if (fd == 0)
			report_failure("cannot open the trace file verif/rx_trace.txt");
		while (fd != 0 && timeouts == 0 && $fgets(line, fd) != 0)
		begin
			if (line.len() < 2 || line.getc(0) == "#")
				continue;
			kind = line.getc(0);
			line = line.substr(1, line.len() - 1);
			case (kind)
				"C":
				begin
					need = 6;
					n = $sscanf(line, "%h %d %d %d %d %d",
						a, v[0], v[1], v[2], v[3], v[4]);
				end
				"F":
				begin
					need = 6;
					n = $sscanf(line, "%d %h %h %d %d %d",
						v[0], v[1], v[2], v[3], v[4], v[5]);
				end
				"T", "E":
				begin
					need = 1;
					n = $sscanf(line, "%d", v[0]);
				end
				default:
				begin
					need = 1;
					n = 0;
				end
			endcase
			if (n != need)
			begin
				report_failure("a trace line could not be read");
				continue;
			end
			if (kind == "C")
				load_ring(a, v[0], v[1], v[2], v[3], v[4]);
			else if (kind == "T")
				load_tail(v[0]);
			else if (kind == "E")
				en_i = (v[0] != 0);
			else
			begin
				expect_frame(v[0], v[1], v[3], v[4], v[5]);
				send_frame(v[0], v[1], v[2]);
			end
		end
		if (fd != 0)
			$fclose(fd);
		if (timeouts == 0)
		begin
			wait_idle();
			repeat (50) @(negedge aclk); // Room for stray writes or pulses
			if (exp_addr.size() != 0 || ev_kind.size() != 0)
				report_failure("expected host writes or interrupts never came");
		end
		$display("errors: %0d mismatches, %0d other failures, %0d host writes seen",
			mismatches, failures, writes_seen);
		if (mismatches == 0 && failures == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- verif/rx_trace.txt
# C rdba(hex) bsize rdlen rdh rdt rdmts | T rdt | E en
# F len first(hex) gap(hex) outcome(0 deliver, 1 overrun, 2 discard) rdh_after thr
C 10000000 0 8 0 6 1
F 64 10 00 0 1 0
F 61 80 55 0 2 0
F 3 f0 00 0 3 0
F 100 33 22 0 4 1
F 45 07 81 0 5 0
F 8 c8 00 0 6 0
F 20 44 00 1 6 0
T 2
F 30 a0 0f 0 7 0
F 40 5a 00 0 0 1
E 0
F 50 11 00 2 0 0
E 1
C 2000 3 4 1 0 0
F 300 e0 24 0 2 1
F 257 01 00 0 3 0
F 255 fe 00 0 0 0

//--- tb.f
logic/rx_bus_pkg.sv
logic/rx_ring_pkg.sv
logic/rx_frame_writer.sv
logic/rx_frame_queue.sv
logic/rx_packet_buffer.sv
logic/rx_ring_ctrl.sv
logic/rx_dma.sv
logic/rx_path.sv
verif/tb_rx_path.sv

//--- run.sh
#!/bin/sh
# Compile and run the rx_path testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_rx_path -o sim_rx_path
./obj_dir/sim_rx_path > sim.log 2>&1
cat sim.log
if grep -q "SOME TESTS FAILED" sim.log
then
	exit 1
fi
exit 0
